// File: verif/exuTests.dat
00500093 1000 1 01 5 1004 0
ffd00113 1004 1 02 fffffffffffffffd 1008 0
40208233 1008 1 04 8 100c 0
40115533 100c 1 0a ffffffffffffffff 1010 0
001125b3 1010 1 0b 1 1014 0
12345837 1014 1 10 12345000 1018 0
00708013 1018 1 00 c 101c 0
001009b3 101c 1 13 5 1020 0
00108863 1020 0 00 0 1030 0
00208863 1024 0 00 0 1028 0
fe209ce3 1028 0 00 0 1020 0
fe109ce3 102c 0 00 0 1030 0
00114863 1030 0 00 0 1040 0
0020c863 1034 0 00 0 1038 0
0020d863 1038 0 00 0 1048 0
00115863 103c 0 00 0 1040 0
0020e863 1040 0 00 0 1050 0
00116863 1044 0 00 0 1048 0
00117863 1048 0 00 0 1058 0
0020f863 104c 0 00 0 1050 0
10000aef 1050 1 15 1054 1150 0
00320b67 1054 1 16 1058 a 0
30581c73 1058 1 18 0 105c 0
30502cf3 105c 1 19 12345000 1060 0
30012d73 1060 1 1a 0 1064 0
3000bdf3 1064 1 1b fffffffffffffffd 1068 0
30002e73 1068 1 1c fffffffffffffff8 106c 0
00000073 2000 0 00 0 12345000 0
34102ef3 12345000 1 1d 2000 12345004 0
34202f73 12345004 1 1e b 12345008 0
30200073 12345008 0 00 0 2000 0
0000b203 2004 0 00 0 2008 1
00020fb3 2008 1 1f 8 200c 0

// File: verilog.f
rtl/exuPkg.sv
rtl/instDecode.sv
rtl/regFile.sv
rtl/aluExec.sv
rtl/csrUnit.sv
rtl/resultSelect.sv
rtl/exuTop.sv
verif/exuTop_properties.sv
verif/exuChecker.sv
verif/exuTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f verilog.f --top-module exuTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VexuTb +verilator+error+limit+100 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All tests passed" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

// File: verif/exuTb.sv
// ----------------------------
// execute subsystem testbench
// ----------------------------
`timescale 1ns/10ps

module exuTb;
    localparam int clkPeriod   = 10;
    localparam int driveDelay  = 1;
    localparam int resetCycles = 16;
    localparam int slackCycles = 20;

    logic clk;
    logic rstN;
    logic instValid;
    logic [31:0] inst;
    logic [exuPkg::xlen-1:0] pc;
    logic wbEn;
    logic [exuPkg::regAddrW-1:0] wbAddr;
    logic [exuPkg::xlen-1:0] wbData;
    logic [exuPkg::xlen-1:0] dnpc;
    logic illegal;

    logic expValid;
    int testId;
    logic expWbEn;
    logic [exuPkg::regAddrW-1:0] expWbAddr;
    logic [exuPkg::xlen-1:0] expWbData;
    logic [exuPkg::xlen-1:0] expDnpc;
    logic expIllegal;
    int passCount;
    int failCount;
    int numTests;
    logic loadDone;

    // one entry per line of the data file
    logic [31:0] tInst [$];
    logic [exuPkg::xlen-1:0] tPc [$];
    logic tWbEn [$];
    logic [exuPkg::regAddrW-1:0] tWbAddr [$];
    logic [exuPkg::xlen-1:0] tWbData [$];
    logic [exuPkg::xlen-1:0] tDnpc [$];
    logic tIllegal [$];

    exuTop exuTop_inst (
        .clk(clk), .rstN(rstN), .instValid(instValid), .inst(inst), .pc(pc),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .dnpc(dnpc), .illegal(illegal)
    );

    exuChecker resultCheck (
        .clk(clk), .expValid(expValid), .testId(testId), .expWbEn(expWbEn),
        .expWbAddr(expWbAddr), .expWbData(expWbData), .expDnpc(expDnpc),
        .expIllegal(expIllegal), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .dnpc(dnpc), .illegal(illegal), .passCount(passCount), .failCount(failCount)
    );

    bind exuTop exuTopProperties propsCheck (
        .clk(clk), .rstN(rstN), .wbEn(wbEn), .illegal(illegal),
        .branch(branch), .dnpc(dnpc)
    );

    task automatic loadTests();
        int fd;
        logic [31:0] fInst;
        logic [exuPkg::xlen-1:0] fPc, fData, fDnpc;
        logic [exuPkg::regAddrW-1:0] fAddr;
        logic fEn, fIll;
        fd = $fopen("verif/exuTests.dat", "r");
        if (fd == 0) begin
            $display("could not open the test data file verif/exuTests.dat");
        end else begin
            while ($fscanf(fd, "%h %h %h %h %h %h %h",
                           fInst, fPc, fEn, fAddr, fData, fDnpc, fIll) == 7) begin
                tInst.push_back(fInst);
                tPc.push_back(fPc);
                tWbEn.push_back(fEn);
                tWbAddr.push_back(fAddr);
                tWbData.push_back(fData);
                tDnpc.push_back(fDnpc);
                tIllegal.push_back(fIll);
            end
            $fclose(fd);
        end
        numTests = tInst.size();
    endtask

    task automatic applyTest(input int idx);
        inst       = tInst[idx];
        pc         = tPc[idx];
        instValid  = 1'b1;
        testId     = idx;
        expWbEn    = tWbEn[idx];
        expWbAddr  = tWbAddr[idx];
        expWbData  = tWbData[idx];
        expDnpc    = tDnpc[idx];
        expIllegal = tIllegal[idx];
        expValid   = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // watchdog sized from the number of tests
    initial begin
        wait (loadDone);
        #((numTests + resetCycles + slackCycles) * clkPeriod);
        $display("timeout: the run did not finish within %0d cycles",
                 numTests + resetCycles + slackCycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rstN       = 1'b0;
        // valid nop while in reset
        instValid  = 1'b1;
        inst       = 32'h0000_0013;
        pc         = '0;
        expValid   = 1'b0;
        testId     = 0;
        expWbEn    = 1'b0;
        expWbAddr  = '0;
        expWbData  = '0;
        expDnpc    = '0;
        expIllegal = 1'b0;
        loadDone   = 1'b0;
        loadTests();
        loadDone = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        for (int i = 0; i < numTests; i++) begin
            applyTest(i);
            @(posedge clk);
            #driveDelay;
        end
        instValid = 1'b0;
        expValid  = 1'b0;
        wait (passCount + failCount == numTests);
        $display("tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 numTests, passCount, failCount, exuTop_inst.propsCheck.failures);
        if (numTests > 0 && failCount == 0 && exuTop_inst.propsCheck.failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verif/exuChecker.sv
// ----------------------------
// execute result checker
// ----------------------------
`timescale 1ns/10ps

module exuChecker (
    input  logic                         clk,
    input  logic                         expValid,
    input  int                           testId,
    input  logic                         expWbEn,
    input  logic [exuPkg::regAddrW-1:0]  expWbAddr,
    input  logic [exuPkg::xlen-1:0]      expWbData,
    input  logic [exuPkg::xlen-1:0]      expDnpc,
    input  logic                         expIllegal,
    input  logic                         wbEn,
    input  logic [exuPkg::regAddrW-1:0]  wbAddr,
    input  logic [exuPkg::xlen-1:0]      wbData,
    input  logic [exuPkg::xlen-1:0]      dnpc,
    input  logic                         illegal,
    output int                           passCount,
    output int                           failCount
);
    // just before the next rising edge
    localparam int sampleDelay = 9;

    task automatic compareOutputs();
        string msg;
        msg = "";
        if (wbEn !== expWbEn) begin
            msg = {msg, $sformatf(" wbEn=%0b expected %0b", wbEn, expWbEn)};
        end
        // write-back fields only count when a write is expected
        if (expWbEn && wbAddr !== expWbAddr) begin
            msg = {msg, $sformatf(" wbAddr=%0d expected %0d", wbAddr, expWbAddr)};
        end
        if (expWbEn && wbData !== expWbData) begin
            msg = {msg, $sformatf(" wbData=%h expected %h", wbData, expWbData)};
        end
        if (dnpc !== expDnpc) begin
            msg = {msg, $sformatf(" dnpc=%h expected %h", dnpc, expDnpc)};
        end
        if (illegal !== expIllegal) begin
            msg = {msg, $sformatf(" illegal=%0b expected %0b", illegal, expIllegal)};
        end
        if (msg == "") begin
            passCount++;
            $display("test %0d passed", testId);
        end else begin
            failCount++;
            $display("FAILED at %0t: test %0d%s", $time, testId, msg);
        end
    endtask

    initial begin
        passCount = 0;
        failCount = 0;
        forever begin
            @(posedge clk);
            #sampleDelay;
            if (expValid) compareOutputs();
        end
    end

endmodule

// File: verif/exuTop_properties.sv
// ----------------------------
// execute top assertions
// ----------------------------
`timescale 1ns/10ps

module exuTopProperties (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     wbEn,
    input  logic                     illegal,
    input  exuPkg::branchE           branch,
    input  logic [exuPkg::xlen-1:0]  dnpc
);
    int failures = 0;

    resetQuiet: assert property (@(posedge clk) !rstN |-> !wbEn)
        else begin
            failures++;
            $error("wbEn high while rstN low");
        end

    illegalQuiet: assert property (@(posedge clk) illegal |-> !wbEn)
        else begin
            failures++;
            $error("wbEn high on an illegal instruction");
        end

    // jalr target has bit 0 cleared
    jalrAligned: assert property (@(posedge clk) branch == exuPkg::brJalr |-> !dnpc[0])
        else begin
            failures++;
            $error("jalr dnpc has bit 0 set");
        end

endmodule

// File: rtl/exuTop.sv
// ----------------------------
// RV64 execute top
// ----------------------------
`timescale 1ns/10ps

module exuTop (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         instValid,
    input  logic [31:0]                  inst,
    input  logic [exuPkg::xlen-1:0]      pc,
    output logic                         wbEn,
    output logic [exuPkg::regAddrW-1:0]  wbAddr,
    output logic [exuPkg::xlen-1:0]      wbData,
    output logic [exuPkg::xlen-1:0]      dnpc,
    output logic                         illegal
);
    logic [exuPkg::regAddrW-1:0] rs1, rs2, rd;
    logic [exuPkg::xlen-1:0] imm, rs1Data, rs2Data, aluRes;
    logic [exuPkg::xlen-1:0] csrRdata, mepc, mtvec;
    logic [exuPkg::csrAddrW-1:0] csrAddr;
    exuPkg::aluOpE aluOp;
    exuPkg::aluSrcAE aluSrcA;
    exuPkg::aluSrcBE aluSrcB;
    exuPkg::branchE branch;
    exuPkg::csrOpE csrOp;
    exuPkg::wbSelE wbSel;
    logic regWen, isEcall, isMret, zero, commit;

    // only legal, valid instructions change state
    assign commit = instValid && !illegal;
    assign wbEn   = commit && regWen && rstN;
    assign wbAddr = rd;

    instDecode decode (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .aluOp(aluOp), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .branch(branch),
        .csrOp(csrOp), .csrAddr(csrAddr), .wbSel(wbSel), .regWen(regWen),
        .isEcall(isEcall), .isMret(isMret), .illegal(illegal)
    );

    regFile regs (
        .clk(clk), .rstN(rstN), .commit(commit), .wen(regWen),
        .raddrA(rs1), .raddrB(rs2), .waddr(rd), .wdata(wbData),
        .rdataA(rs1Data), .rdataB(rs2Data)
    );

    aluExec alu (
        .aluOp(aluOp), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .pc(pc), .imm(imm),
        .aluRes(aluRes), .zero(zero)
    );

    csrUnit csr (
        .clk(clk), .rstN(rstN), .commit(commit), .csrOp(csrOp), .csrAddr(csrAddr),
        .csrWdata(rs1Data), .isEcall(isEcall), .pc(pc),
        .csrRdata(csrRdata), .mepc(mepc), .mtvec(mtvec)
    );

    resultSelect result (
        .branch(branch), .wbSel(wbSel), .isEcall(isEcall), .isMret(isMret),
        .zero(zero), .aluRes(aluRes), .pc(pc), .imm(imm), .rs1Data(rs1Data),
        .csrRdata(csrRdata), .mepc(mepc), .mtvec(mtvec),
        .dnpc(dnpc), .wbData(wbData)
    );

endmodule

// File: rtl/resultSelect.sv
// ----------------------------
// next pc and write-back
// ----------------------------
`timescale 1ns/10ps

module resultSelect (
    input  exuPkg::branchE            branch,
    input  exuPkg::wbSelE             wbSel,
    input  logic                      isEcall,
    input  logic                      isMret,
    input  logic                      zero,
    input  logic [exuPkg::xlen-1:0]   aluRes,
    input  logic [exuPkg::xlen-1:0]   pc,
    input  logic [exuPkg::xlen-1:0]   imm,
    input  logic [exuPkg::xlen-1:0]   rs1Data,
    input  logic [exuPkg::xlen-1:0]   csrRdata,
    input  logic [exuPkg::xlen-1:0]   mepc,
    input  logic [exuPkg::xlen-1:0]   mtvec,
    output logic [exuPkg::xlen-1:0]   dnpc,
    output logic [exuPkg::xlen-1:0]   wbData
);
    logic taken;
    logic [exuPkg::xlen-1:0] pcPlus4, pcPlusImm, jalrTarget;

    assign pcPlus4    = pc + 64'd4;
    assign pcPlusImm  = pc + imm;
    assign jalrTarget = (rs1Data + imm) & ~64'd1;

    // aluRes[0] holds the slt/sltu outcome for ordered compares
    always_comb begin
        case (branch)
            exuPkg::brJal:  taken = 1'b1;
            exuPkg::brEq:   taken = zero;
            exuPkg::brNe:   taken = !zero;
            exuPkg::brLt:   taken = aluRes[0];
            exuPkg::brGe:   taken = !aluRes[0];
            exuPkg::brLtu:  taken = aluRes[0];
            exuPkg::brGeu:  taken = !aluRes[0];
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        if (isEcall) dnpc = mtvec;
        else if (isMret) dnpc = mepc;
        else if (branch == exuPkg::brJalr) dnpc = jalrTarget;
        else if (taken) dnpc = pcPlusImm;
        else dnpc = pcPlus4;
    end

    always_comb begin
        case (wbSel)
            exuPkg::wbCsr:     wbData = csrRdata;
            exuPkg::wbPcPlus4: wbData = pcPlus4;
            default:           wbData = aluRes;
        endcase
    end

endmodule

// File: rtl/csrUnit.sv
// ----------------------------
// machine CSR unit
// ----------------------------
`timescale 1ns/10ps

module csrUnit (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         commit,
    input  exuPkg::csrOpE                csrOp,
    input  logic [exuPkg::csrAddrW-1:0]  csrAddr,
    input  logic [exuPkg::xlen-1:0]      csrWdata,
    input  logic                         isEcall,
    input  logic [exuPkg::xlen-1:0]      pc,
    output logic [exuPkg::xlen-1:0]      csrRdata,
    output logic [exuPkg::xlen-1:0]      mepc,
    output logic [exuPkg::xlen-1:0]      mtvec
);
    logic [exuPkg::xlen-1:0] mstatusQ, mtvecQ, mepcQ, mcauseQ;
    logic [exuPkg::xlen-1:0] csrNext;
    logic csrWen;

    always_comb begin
        case (csrAddr)
            exuPkg::csrMstatus: csrRdata = mstatusQ;
            exuPkg::csrMtvec:   csrRdata = mtvecQ;
            exuPkg::csrMepc:    csrRdata = mepcQ;
            exuPkg::csrMcause:  csrRdata = mcauseQ;
            default:            csrRdata = '0;
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (csrOp)
            exuPkg::csrWrite: csrNext = csrWdata;
            exuPkg::csrSet:   csrNext = csrRdata | csrWdata;
            exuPkg::csrClear: csrNext = csrRdata & ~csrWdata;
            default:          csrNext = csrRdata;
        endcase
    end

    assign csrWen = commit && csrOp != exuPkg::csrNone;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mstatusQ <= '0;
            mtvecQ   <= '0;
            mepcQ    <= '0;
            mcauseQ  <= '0;
        end else if (commit && isEcall) begin
            mepcQ   <= pc;
            mcauseQ <= exuPkg::ecallCause;
        end else if (csrWen) begin
            if (csrAddr == exuPkg::csrMstatus) mstatusQ <= csrNext;
            if (csrAddr == exuPkg::csrMtvec) mtvecQ <= csrNext;
            if (csrAddr == exuPkg::csrMepc) mepcQ <= csrNext;
            if (csrAddr == exuPkg::csrMcause) mcauseQ <= csrNext;
        end
    end

    assign mepc  = mepcQ;
    assign mtvec = mtvecQ;

endmodule

// File: rtl/aluExec.sv
// ----------------------------
// 64-bit ALU
// ----------------------------
`timescale 1ns/10ps

module aluExec (
    input  exuPkg::aluOpE             aluOp,
    input  exuPkg::aluSrcAE           aluSrcA,
    input  exuPkg::aluSrcBE           aluSrcB,
    input  logic [exuPkg::xlen-1:0]   rs1Data,
    input  logic [exuPkg::xlen-1:0]   rs2Data,
    input  logic [exuPkg::xlen-1:0]   pc,
    input  logic [exuPkg::xlen-1:0]   imm,
    output logic [exuPkg::xlen-1:0]   aluRes,
    output logic                      zero
);
    logic [exuPkg::xlen-1:0] opA;
    logic [exuPkg::xlen-1:0] opB;
    logic [5:0] shamt;

    assign opA = (aluSrcA == exuPkg::srcAPc) ? pc : rs1Data;

    always_comb begin
        case (aluSrcB)
            exuPkg::srcBRs2:  opB = rs2Data;
            exuPkg::srcBImm:  opB = imm;
            exuPkg::srcBFour: opB = 64'd4;
            default:          opB = '0;
        endcase
    end

    // RV64 shifts use six bits of operand B
    assign shamt = opB[5:0];

    always_comb begin
        aluRes = '0;
        case (aluOp)
            exuPkg::aluAdd:  aluRes = opA + opB;
            exuPkg::aluSub:  aluRes = opA - opB;
            exuPkg::aluAnd:  aluRes = opA & opB;
            exuPkg::aluOr:   aluRes = opA | opB;
            exuPkg::aluXor:  aluRes = opA ^ opB;
            exuPkg::aluSll:  aluRes = opA << shamt;
            exuPkg::aluSrl:  aluRes = opA >> shamt;
            exuPkg::aluSra:  aluRes = $signed(opA) >>> shamt;
            exuPkg::aluSlt:  aluRes[0] = $signed(opA) < $signed(opB);
            exuPkg::aluSltu: aluRes[0] = opA < opB;
            default:         aluRes = '0;
        endcase
    end

    // eq/ne branches look at this after a subtract
    assign zero = (aluRes == '0);

endmodule

// File: rtl/regFile.sv
// ----------------------------
// integer register file
// ----------------------------
`timescale 1ns/10ps

module regFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         commit,
    input  logic                         wen,
    input  logic [exuPkg::regAddrW-1:0]  raddrA,
    input  logic [exuPkg::regAddrW-1:0]  raddrB,
    input  logic [exuPkg::regAddrW-1:0]  waddr,
    input  logic [exuPkg::xlen-1:0]      wdata,
    output logic [exuPkg::xlen-1:0]      rdataA,
    output logic [exuPkg::xlen-1:0]      rdataB
);
    logic [exuPkg::xlen-1:0] regs [2**exuPkg::regAddrW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**exuPkg::regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

// File: rtl/instDecode.sv
// ----------------------------
// RV64 instruction decode
// ----------------------------
`timescale 1ns/10ps

module instDecode (
    input  logic [31:0]                  inst,
    output logic [exuPkg::regAddrW-1:0]  rs1,
    output logic [exuPkg::regAddrW-1:0]  rs2,
    output logic [exuPkg::regAddrW-1:0]  rd,
    output logic [exuPkg::xlen-1:0]      imm,
    output exuPkg::aluOpE                aluOp,
    output exuPkg::aluSrcAE              aluSrcA,
    output exuPkg::aluSrcBE              aluSrcB,
    output exuPkg::branchE               branch,
    output exuPkg::csrOpE                csrOp,
    output logic [exuPkg::csrAddrW-1:0]  csrAddr,
    output exuPkg::wbSelE                wbSel,
    output logic                         regWen,
    output logic                         isEcall,
    output logic                         isMret,
    output logic                         illegal
);
    exuPkg::opcodeE opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [exuPkg::xlen-1:0] immI, immB, immU, immJ;
    logic csrKnown;

    assign opcode  = exuPkg::opcodeE'(inst[6:0]);
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs2     = inst[24:20];
    assign rd      = inst[11:7];
    assign csrAddr = inst[31:20];

    // sign-extended immediate formats
    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign csrKnown = csrAddr inside {exuPkg::csrMstatus, exuPkg::csrMtvec,
                                      exuPkg::csrMepc, exuPkg::csrMcause};

    always_comb begin
        rs1     = inst[19:15];
        imm     = immI;
        aluOp   = exuPkg::aluAdd;
        aluSrcA = exuPkg::srcARs1;
        aluSrcB = exuPkg::srcBImm;
        branch  = exuPkg::brNone;
        csrOp   = exuPkg::csrNone;
        wbSel   = exuPkg::wbAlu;
        regWen  = 1'b0;
        isEcall = 1'b0;
        isMret  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            exuPkg::opImm: begin
                regWen = 1'b1;
                // only srai carries the alternate bit
                aluOp = exuPkg::aluOpE'({inst[30] && funct3 == 3'b101, funct3});
                if (funct3 == 3'b001) illegal = inst[31:26] != 6'b0;
                if (funct3 == 3'b101) illegal = {inst[31], inst[29:26]} != 5'b0;
            end
            exuPkg::opReg: begin
                regWen  = 1'b1;
                aluSrcB = exuPkg::srcBRs2;
                aluOp   = exuPkg::aluOpE'({inst[30], funct3});
                illegal = !(funct7 == 7'b0 ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            exuPkg::opLui: begin
                // x0 as operand A turns the add into a pass of imm
                rs1    = '0;
                imm    = immU;
                regWen = 1'b1;
            end
            exuPkg::opAuipc: begin
                imm     = immU;
                aluSrcA = exuPkg::srcAPc;
                regWen  = 1'b1;
            end
            exuPkg::opBranch: begin
                imm     = immB;
                aluSrcB = exuPkg::srcBRs2;
                case (funct3)
                    3'b000: begin
                        branch = exuPkg::brEq;
                        aluOp  = exuPkg::aluSub;
                    end
                    3'b001: begin
                        branch = exuPkg::brNe;
                        aluOp  = exuPkg::aluSub;
                    end
                    3'b100: begin
                        branch = exuPkg::brLt;
                        aluOp  = exuPkg::aluSlt;
                    end
                    3'b101: begin
                        branch = exuPkg::brGe;
                        aluOp  = exuPkg::aluSlt;
                    end
                    3'b110: begin
                        branch = exuPkg::brLtu;
                        aluOp  = exuPkg::aluSltu;
                    end
                    3'b111: begin
                        branch = exuPkg::brGeu;
                        aluOp  = exuPkg::aluSltu;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            exuPkg::opJal, exuPkg::opJalr: begin
                imm     = (opcode == exuPkg::opJal) ? immJ : immI;
                aluSrcA = exuPkg::srcAPc;
                aluSrcB = exuPkg::srcBFour;
                wbSel   = exuPkg::wbPcPlus4;
                regWen  = 1'b1;
                if (opcode == exuPkg::opJal) begin
                    branch = exuPkg::brJal;
                end else begin
                    branch  = exuPkg::brJalr;
                    illegal = funct3 != 3'b000;
                end
            end
            exuPkg::opSystem: begin
                if (funct3 == 3'b000) begin
                    if (inst == 32'h0000_0073) isEcall = 1'b1;
                    else if (inst == 32'h3020_0073) isMret = 1'b1;
                    else illegal = 1'b1;
                end else if (funct3[2] == 1'b0) begin
                    csrOp   = exuPkg::csrOpE'(funct3[1:0]);
                    wbSel   = exuPkg::wbCsr;
                    regWen  = 1'b1;
                    illegal = !csrKnown;
                end else begin
                    // immediate CSR forms not implemented
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: rtl/exuPkg.sv
// ----------------------------
// RV64 execute definitions
// ----------------------------
package exuPkg;

    localparam int xlen     = 64;
    localparam int regAddrW = 5;
    localparam int csrAddrW = 12;

    // implemented machine CSRs
    localparam logic [csrAddrW-1:0] csrMstatus = 12'h300;
    localparam logic [csrAddrW-1:0] csrMtvec   = 12'h305;
    localparam logic [csrAddrW-1:0] csrMepc    = 12'h341;
    localparam logic [csrAddrW-1:0] csrMcause  = 12'h342;

    // environment call from M-mode
    localparam logic [xlen-1:0] ecallCause = 64'd11;

    typedef enum logic [6:0] {
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opSystem = 7'b1110011
    } opcodeE;

    // encoded as {funct7[5], funct3} so decode can cast directly
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOpE;

    typedef enum logic {
        srcARs1,
        srcAPc
    } aluSrcAE;

    typedef enum logic [1:0] {
        srcBRs2,
        srcBImm,
        srcBFour
    } aluSrcBE;

    typedef enum logic [3:0] {
        brNone,
        brJal,
        brJalr,
        brEq,
        brNe,
        brLt,
        brGe,
        brLtu,
        brGeu
    } branchE;

    // matches funct3[1:0] of csrrw/csrrs/csrrc
    typedef enum logic [1:0] {
        csrNone  = 2'b00,
        csrWrite = 2'b01,
        csrSet   = 2'b10,
        csrClear = 2'b11
    } csrOpE;

    typedef enum logic [1:0] {
        wbAlu,
        wbCsr,
        wbPcPlus4
    } wbSelE;

endpackage
